/* files.f */
ex_pkg.sv
ex_alu.sv
ex_decode.sv
ex_execute.sv
ex_result.sv
ex_top.sv
tb_ex_checker.sv
tb_ex_top.sv

/* tb_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

    import ex_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int OUT_CREDITS    = 2;
    localparam int ISSUE_COUNT    = 400;
    localparam int TIMEOUT_CYCLES = ISSUE_COUNT * 20;
    localparam int SEED           = 32'hc16562ab;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    issue_t      issue;
    logic        credit_up;
    logic        res_valid;
    result_t     res;
    logic        credit_dn;
    result_t     exp_res;
    integer      seed;
    integer      credit_seed;
    int          up_credits;
    int          dn_given;
    int          issued;
    int          end_errors;
    int          cycles = 0;
    logic [31:0] check_errors;
    logic [31:0] results;
    logic [31:0] credit_pulses;
    logic [31:0] pending;

    ex_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) ex_top_inst (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .credit_o      (credit_up),
        .res_valid_o   (res_valid),
        .res_o         (res),
        .credit_i      (credit_dn)
    );

    tb_ex_checker #(
        .OUT_CREDITS (OUT_CREDITS)
    ) tb_ex_checker_inst (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .issue_valid_i   (issue_valid),
        .issue_i         (issue),
        .exp_i           (exp_res),
        .res_valid_i     (res_valid),
        .res_i           (res),
        .credit_up_i     (credit_up),
        .credit_dn_i     (credit_dn),
        .errors_o        (check_errors),
        .results_o       (results),
        .credit_pulses_o (credit_pulses),
        .pending_o       (pending)
    );

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    function automatic logic [31:0] shift_right_arith(input logic [31:0] a,
                                                      input logic [4:0] s);
        logic [31:0] fill;
        fill = a[31] ? ~(32'hffff_ffff >> s) : 32'd0;   // Sign copies into the vacated bits.
        return (a >> s) | fill;
    endfunction

    function automatic logic [31:0] int_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return signed_less(a, b) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return signed_less(a, b);
            3'b101:  return !signed_less(a, b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic result_t expected_result(input issue_t it);
        result_t    r;
        logic [2:0] f3;
        f3          = it.inst[14:12];
        r.reg_wen   = it.reg_wen;
        r.reg_waddr = it.reg_waddr;
        r.reg_wdata = '0;
        r.jump_flag = 1'b0;
        r.jump_addr = '0;
        case (it.inst[6:0])
            OPC_R: r.reg_wdata = int_result(f3, it.inst[30], it.op1, it.op2);
            OPC_I: r.reg_wdata = int_result(f3, it.inst[30] && f3 == 3'b101, it.op1, it.offset);
            OPC_B: begin
                r.reg_wen = 1'b0;
                if (branch_taken(f3, it.op1, it.op2)) begin
                    r.jump_flag = 1'b1;
                    r.jump_addr = it.inst_addr + it.offset;
                end
            end
            OPC_JAL: begin
                r.reg_wdata = it.inst_addr + 32'd4;
                r.jump_flag = 1'b1;
                r.jump_addr = it.inst_addr + it.offset;
            end
            OPC_JALR: begin
                r.reg_wdata = it.inst_addr + 32'd4;
                r.jump_flag = 1'b1;
                r.jump_addr = (it.op1 + it.offset) & ~32'd1;
            end
            OPC_LUI:   r.reg_wdata = it.op1;
            OPC_AUIPC: r.reg_wdata = it.inst_addr + it.offset;
            default:   r.reg_wen = 1'b0;
        endcase
        return r;
    endfunction

    task automatic make_issue(output issue_t it);
        logic [31:0] r;
        logic [2:0]  f3;
        r            = $random(seed);
        it.inst      = $random(seed);
        it.op1       = r[3] ? {28'b0, r[27:24]} : $random(seed);
        it.op2       = r[2] ? it.op1 : $random(seed);  // Equal operands show up often.
        it.offset    = {{20{r[31]}}, r[31:20]};
        it.inst_addr = $random(seed);
        it.inst_addr[1:0] = 2'b00;
        it.reg_wen   = (r[7:5] != 3'd0);
        it.reg_waddr = r[12:8];
        f3           = r[15:13];
        if (r[4:0] < 5'd7) begin
            it.inst[6:0] = OPC_R;
        end else if (r[4:0] < 5'd14) begin
            it.inst[6:0] = OPC_I;
        end else if (r[4:0] < 5'd23) begin
            if (f3[2:1] == 2'b01) begin
                f3[1] = 1'b0;                  // Func3 010 and 011 name no branch.
            end
            it.inst[6:0]   = OPC_B;
            it.inst[14:12] = f3;
            it.offset[0]   = 1'b0;
        end else if (r[4:0] < 5'd25) begin
            it.inst[6:0] = OPC_JAL;
            it.offset[0] = 1'b0;
        end else if (r[4:0] < 5'd27) begin
            it.inst[6:0] = OPC_JALR;
        end else if (r[4:0] < 5'd29) begin
            it.inst[6:0] = OPC_LUI;
            it.offset    = {it.inst[31:12], 12'b0};
            it.op1       = it.offset;
        end else if (r[4:0] < 5'd31) begin
            it.inst[6:0] = OPC_AUIPC;
            it.offset    = {it.inst[31:12], 12'b0};
        end else begin
            it.inst[6:0] = r[16] ? 7'b1110011 : 7'b0000011;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (credit_up) begin
            up_credits++;
        end
        if (up_credits > FIFO_DEPTH) begin
            end_errors++;
            $display("upstream credits rose to %0d, above the queue depth", up_credits);
            up_credits = FIFO_DEPTH;
        end
    endtask

    task automatic print_counts();
        $display("issued %0d, results %0d, credit pulses %0d, errors %0d",
                 issued, results, credit_pulses, check_errors + end_errors);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin : credit_source
        int          gap;
        logic [31:0] r;
        credit_seed = SEED;
        credit_dn   = 1'b0;
        dn_given    = 0;
        gap         = 0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            credit_dn = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (dn_given < results) begin  // Never hold more than the reset grant.
                credit_dn = 1'b1;
                dn_given++;
                r   = $random(credit_seed);
                gap = (r[4:0] == 5'd0) ? 30 + r[9:5] : r[6:5];
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     cycles, results, ISSUE_COUNT);
            print_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin : main
        seed        = SEED;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        exp_res     = '0;
        up_credits  = FIFO_DEPTH;
        issued      = 0;
        end_errors  = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (5) next_cycle();
        while (issued < ISSUE_COUNT) begin
            next_cycle();
            issue_valid = 1'b0;
            if (up_credits > 0 && $random(seed) % 4 != 0) begin
                make_issue(issue);
                exp_res     = expected_result(issue);
                issue_valid = 1'b1;
                up_credits--;
                issued++;
            end
        end
        next_cycle();
        issue_valid = 1'b0;
        while (results < ISSUE_COUNT) begin
            next_cycle();
        end
        repeat (20) next_cycle();               // Room for a duplicated result to show up.
        if (pending != 0) begin
            end_errors++;
            $display("%0d expected results were never delivered", pending);
        end
        if (credit_pulses != results) begin
            end_errors++;
            $display("credit_o pulsed %0d times for %0d results", credit_pulses, results);
        end
        print_counts();
        if (check_errors + end_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_ex_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_checker #(
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            issue_valid_i,
    input  ex_pkg::issue_t  issue_i,
    input  ex_pkg::result_t exp_i,
    input  logic            res_valid_i,
    input  ex_pkg::result_t res_i,
    input  logic            credit_up_i,
    input  logic            credit_dn_i,
    output logic [31:0]     errors_o,
    output logic [31:0]     results_o,
    output logic [31:0]     credit_pulses_o,
    output logic [31:0]     pending_o
);

    import ex_pkg::*;

    result_t    exp_q[$];
    int         cycle_q[$];
    logic [6:0] opc_q[$];
    int         cycle;
    int         held;
    logic       pulse_d;
    logic       seen_issue;

    initial begin
        errors_o        = '0;
        results_o       = '0;
        credit_pulses_o = '0;
        pending_o       = '0;
        cycle           = 0;
        held            = OUT_CREDITS;
        pulse_d         = 1'b0;
        seen_issue      = 1'b0;
    end

    function automatic string kind_name(input logic [6:0] opc);
        case (opc)
            OPC_R:     return "reg-reg ALU";
            OPC_I:     return "reg-imm ALU";
            OPC_B:     return "branch";
            OPC_JAL:   return "JAL";
            OPC_JALR:  return "JALR";
            OPC_LUI:   return "LUI";
            OPC_AUIPC: return "AUIPC";
            default:   return "unknown opcode";
        endcase
    endfunction

    task automatic compare_field(input string name, input int idx, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors_o = errors_o + 1;
            $display("mismatch %s #%0d %s: expected %h, actual %h",
                     name, idx, field, expected, actual);
        end
    endtask

    task automatic check_result();
        result_t    want;
        int         issued_at;
        string      name;
        if (exp_q.size() == 0) begin
            errors_o = errors_o + 1;
            $display("a result arrived with no instruction outstanding");
        end else begin
            want      = exp_q.pop_front();
            issued_at = cycle_q.pop_front();
            name      = kind_name(opc_q.pop_front());
            if (cycle - issued_at < 3) begin
                errors_o = errors_o + 1;
                $display("%s #%0d came out %0d cycles after its issue, sooner than 3",
                         name, results_o, cycle - issued_at);
            end
            compare_field(name, results_o, "reg_wen", want.reg_wen, res_i.reg_wen);
            compare_field(name, results_o, "jump_flag", want.jump_flag, res_i.jump_flag);
            compare_field(name, results_o, "jump_addr", want.jump_addr, res_i.jump_addr);
            if (want.reg_wen) begin             // Write data only matters when it is written.
                compare_field(name, results_o, "reg_waddr", want.reg_waddr, res_i.reg_waddr);
                compare_field(name, results_o, "reg_wdata", want.reg_wdata, res_i.reg_wdata);
            end
        end
        results_o = results_o + 1;
    endtask

    always @(posedge clk_i) begin
        cycle = cycle + 1;
        if (rst_n_i) begin
            if (!seen_issue && (res_valid_i || credit_up_i)) begin
                errors_o = errors_o + 1;
                $display("res_valid_o or credit_o went high before the first issue");
            end
            if (res_valid_i && held <= 0) begin
                errors_o = errors_o + 1;
                $display("a result was sent while no downstream credit was outstanding");
            end
            if (res_valid_i) begin
                held = held - 1;
            end
            if (pulse_d) begin
                held = held + 1;                // The DUT counts a pulse one edge later.
            end
            pulse_d = credit_dn_i;
            if (credit_up_i) begin
                credit_pulses_o = credit_pulses_o + 1;
            end
            if (res_valid_i) begin
                check_result();
            end
            if (issue_valid_i) begin
                exp_q.push_back(exp_i);
                cycle_q.push_back(cycle);
                opc_q.push_back(issue_i.inst[6:0]);
                seen_issue = 1'b1;
            end
            pending_o = exp_q.size();
        end
    end

endmodule

`default_nettype wire

/* ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            issue_valid_i,
    input  ex_pkg::issue_t  issue_i,
    output logic            credit_o,
    output logic            res_valid_o,
    output ex_pkg::result_t res_o,
    input  logic            credit_i
);

    import ex_pkg::*;

    logic    ctrl_valid;
    ctrl_t   ctrl;
    logic    exe_valid;
    result_t exe_res;

    ex_decode u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .ctrl_valid_o  (ctrl_valid),
        .ctrl_o        (ctrl)
    );

    ex_execute u_execute (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl_valid_i (ctrl_valid),
        .ctrl_i       (ctrl),
        .res_valid_o  (exe_valid),
        .res_o        (exe_res)
    );

    ex_result #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_result (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (exe_valid),
        .in_i        (exe_res),
        .credit_i    (credit_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .credit_o    (credit_o)
    );

endmodule

`default_nettype wire

/* ex_result.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_result #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            in_valid_i,
    input  ex_pkg::result_t in_i,
    input  logic            credit_i,
    output logic            res_valid_o,
    output ex_pkg::result_t res_o,
    output logic            credit_o
);

    import ex_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    result_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             empty;
    logic             send;
    logic             push;
    logic             pop;
    logic             sent_q;
    result_t          head;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign send  = (credits != '0) && (!empty || in_valid_i);
    assign pop   = send && !empty;
    assign push  = in_valid_i && !(send && empty);  // An empty queue hands the input straight out.
    assign head  = empty ? in_i : mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Each send spends one downstream credit.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits <= CRD_W'(OUT_CREDITS);
        end else begin
            case ({credit_i, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sent_q <= 1'b0;
        end else begin
            sent_q <= send;
        end
    end

    always_ff @(posedge clk_i) begin
        res_o <= head;
    end

    assign res_valid_o = sent_q;
    assign credit_o    = sent_q;                // Each departure frees one upstream slot.

endmodule

`default_nettype wire

/* ex_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_execute (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            ctrl_valid_i,
    input  ex_pkg::ctrl_t   ctrl_i,
    output logic            res_valid_o,
    output ex_pkg::result_t res_o
);

    import ex_pkg::*;

    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic            alu_zero;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] link_addr;
    logic            is_branch;
    logic            taken;
    result_t         res_d;

    assign alu_b = ctrl_i.op2_sel ? ctrl_i.offset : ctrl_i.op2;

    ex_alu u_alu (
        .a_i    (ctrl_i.op1),
        .b_i    (alu_b),
        .op_i   (ctrl_i.alu_op),
        .res_o  (alu_res),
        .zero_o (alu_zero)
    );

    assign pc_target = ctrl_i.inst_addr + ctrl_i.offset;
    assign link_addr = ctrl_i.inst_addr + 32'd4;
    assign is_branch = ctrl_i.br_cond inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};

    always_comb begin
        case (ctrl_i.br_cond)
            BR_EQ:         taken = alu_zero;
            BR_NE:         taken = !alu_zero;
            BR_LT,
            BR_LTU:        taken = alu_res[0];  // SLT or SLTU result.
            BR_GE,
            BR_GEU:        taken = !alu_res[0];
            BR_ALWAYS,
            BR_ALWAYS_REG: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
    end

    always_comb begin
        res_d.reg_wen   = ctrl_i.reg_wen && !is_branch;
        res_d.reg_waddr = ctrl_i.reg_waddr;
        res_d.jump_flag = taken;
        if (!taken) begin
            res_d.jump_addr = '0;
        end else if (ctrl_i.br_cond == BR_ALWAYS_REG) begin
            res_d.jump_addr = {alu_res[XLEN-1:1], 1'b0};
        end else begin
            res_d.jump_addr = pc_target;
        end
        case (ctrl_i.wb_sel)
            WB_LINK: res_d.reg_wdata = link_addr;
            WB_OP1:  res_d.reg_wdata = ctrl_i.op1;
            default: res_d.reg_wdata = alu_res;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= ctrl_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        res_o <= res_d;
    end

endmodule

`default_nettype wire

/* ex_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_decode (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           issue_valid_i,
    input  ex_pkg::issue_t issue_i,
    output logic           ctrl_valid_o,
    output ex_pkg::ctrl_t  ctrl_o
);

    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    alu_op_e    int_op;
    ctrl_t      ctrl_d;

    assign opcode = issue_i.inst[6:0];
    assign func3  = issue_i.inst[14:12];
    assign func7  = issue_i.inst[31:25];

    // Shared by register and immediate forms; SUB exists only in the register form.
    always_comb begin
        case (func3)
            F3_ADD:  int_op = (func7[5] && opcode == OPC_R) ? ALU_SUB : ALU_ADD;
            F3_SLL:  int_op = ALU_SLL;
            F3_SLT:  int_op = ALU_SLT;
            F3_SLTU: int_op = ALU_SLTU;
            F3_XOR:  int_op = ALU_XOR;
            F3_SR:   int_op = func7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   int_op = ALU_OR;
            default: int_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_d.alu_op    = ALU_PASS;
        ctrl_d.wb_sel    = WB_ALU;
        ctrl_d.br_cond   = BR_NONE;
        ctrl_d.op2_sel   = 1'b0;
        ctrl_d.op1       = issue_i.op1;
        ctrl_d.op2       = issue_i.op2;
        ctrl_d.offset    = issue_i.offset;
        ctrl_d.inst_addr = issue_i.inst_addr;
        ctrl_d.reg_wen   = issue_i.reg_wen;
        ctrl_d.reg_waddr = issue_i.reg_waddr;

        case (opcode)
            OPC_R: begin
                ctrl_d.alu_op = int_op;
            end
            OPC_I: begin
                ctrl_d.alu_op  = int_op;
                ctrl_d.op2_sel = 1'b1;              // Immediate arrives in the offset field.
            end
            OPC_B: begin
                case (func3)
                    F3_BEQ:  ctrl_d.br_cond = BR_EQ;
                    F3_BNE:  ctrl_d.br_cond = BR_NE;
                    F3_BLT:  ctrl_d.br_cond = BR_LT;
                    F3_BGE:  ctrl_d.br_cond = BR_GE;
                    F3_BLTU: ctrl_d.br_cond = BR_LTU;
                    F3_BGEU: ctrl_d.br_cond = BR_GEU;
                    default: ctrl_d.reg_wen = 1'b0;
                endcase
                if (func3[2]) begin
                    ctrl_d.alu_op = func3[1] ? ALU_SLTU : ALU_SLT;
                end else begin
                    ctrl_d.alu_op = ALU_SUB;        // Zero result means equal.
                end
            end
            OPC_JAL: begin
                ctrl_d.wb_sel  = WB_LINK;
                ctrl_d.br_cond = BR_ALWAYS;
            end
            OPC_JALR: begin
                ctrl_d.alu_op  = ALU_ADD;
                ctrl_d.op2_sel = 1'b1;
                ctrl_d.wb_sel  = WB_LINK;
                ctrl_d.br_cond = BR_ALWAYS_REG;
            end
            OPC_LUI: begin
                ctrl_d.wb_sel = WB_OP1;
            end
            OPC_AUIPC: begin
                ctrl_d.alu_op  = ALU_ADD;
                ctrl_d.op2_sel = 1'b1;
                ctrl_d.op1     = issue_i.inst_addr; // The ALU adds the offset to the PC.
            end
            default: begin
                ctrl_d.reg_wen = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_valid_o <= 1'b0;
        end else begin
            ctrl_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        ctrl_o <= ctrl_d;
    end

endmodule

`default_nettype wire

/* ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  logic [ex_pkg::XLEN-1:0] a_i,
    input  logic [ex_pkg::XLEN-1:0] b_i,
    input  ex_pkg::alu_op_e         op_i,
    output logic [ex_pkg::XLEN-1:0] res_o,
    output logic                    zero_o
);

    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  res_o = a_i + b_i;
            ALU_SUB:  res_o = a_i - b_i;
            ALU_SLL:  res_o = a_i << shamt;
            ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  res_o = a_i ^ b_i;
            ALU_SRL:  res_o = a_i >> shamt;
            ALU_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:   res_o = a_i | b_i;
            ALU_AND:  res_o = a_i & b_i;
            ALU_PASS: res_o = a_i;
            default:  res_o = '0;
        endcase
    end

    assign zero_o = (res_o == '0);          // Used by BEQ and BNE after a subtract.

endmodule

`default_nettype wire

/* ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    localparam logic [2:0] F3_ADD  = 3'b000;    // Also SUB when func7 bit 5 is set.
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // Logical right shift unless func7 bit 5 asks for SRA.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS                                // Passes operand a unchanged.
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK,
        WB_OP1
    } wb_sel_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS,                              // JAL jumps relative to inst_addr.
        BR_ALWAYS_REG                           // JALR jumps relative to op1.
    } br_cond_e;

    typedef struct packed {
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       offset;
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       inst_addr;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] reg_waddr;
    } issue_t;

    typedef struct packed {
        alu_op_e               alu_op;
        wb_sel_e               wb_sel;
        br_cond_e              br_cond;
        logic                  op2_sel;         // Set to feed the offset into ALU operand b.
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       offset;
        logic [XLEN-1:0]       inst_addr;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] reg_waddr;
    } ctrl_t;

    typedef struct packed {
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] reg_waddr;
        logic [XLEN-1:0]       reg_wdata;
        logic                  jump_flag;
        logic [XLEN-1:0]       jump_addr;
    } result_t;

endpackage

`default_nettype wire
